//--- Makefile
# Verilator build and run of the vector functional unit testbench

TOP = tb_vfu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- flist.f
source/vfu_pkg.sv
source/vfu_op_queue.sv
source/vfu_issue_ctrl.sv
source/vfu_lane.sv
source/vfu_writeback.sv
source/vfu_top.sv
testbench/tb_vrf_model.sv
testbench/tb_vfu.sv

//--- source/vfu_issue_ctrl.sv
// Issue control of the vector functional unit.
// Walks an instruction word by word, addresses the VRF, builds lane operands
// and the per-word tag with the tail byte mask.

`timescale 1ns/10ps
`default_nettype none

module vfu_issue_ctrl #(
  parameter int unsigned N_LANES = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  vfu_pkg::vfu_req_t                     req_i,
  input  logic                                  req_valid_i,
  output logic                                  req_ready_o,
  output vfu_pkg::vreg_addr_t [1:0]             vrf_raddr_o,
  output logic [1:0]                            vrf_re_o,
  input  logic [1:0]                            vrf_rvalid_i,
  input  logic [1:0][N_LANES*vfu_pkg::ELEN-1:0] vrf_rdata_i,
  output vfu_pkg::lane_in_t [N_LANES-1:0]       lane_in_o,
  output logic                                  lane_valid_o,
  input  logic [N_LANES-1:0]                    lane_ready_i,
  output vfu_pkg::vfu_tag_t                     tag_o
);
  import vfu_pkg::*;

  localparam int unsigned NB = N_LANES * ELENB;

  logic [8:0] cnt_q;
  logic [7:0] word_q;
  logic [8:0] elem_per_word;
  logic [8:0] cnt_next;
  logic       last_word;
  logic       operands_ok;
  lane_word_u rs1_rep;

  //////////////////////////////////////////////////
  // Element counter
  //////////////////////////////////////////////////

  assign elem_per_word = 9'(NB) >> req_i.vsew;
  assign cnt_next      = cnt_q + elem_per_word;
  assign last_word     = req_i.is_scalar || (cnt_next >= {1'b0, req_i.vl});

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      word_q <= '0;
    end else if (lane_valid_o) begin
      if (last_word) begin
        cnt_q  <= '0;
        word_q <= '0;
      end else begin
        cnt_q  <= cnt_next;
        word_q <= word_q + 8'd1;
      end
    end
  end

  //////////////////////////////////////////////////
  // VRF reads and issue handshake
  //////////////////////////////////////////////////

  // Port 0 reads vs2, port 1 reads vs1
  assign vrf_re_o[0]    = req_valid_i && !req_i.is_scalar;
  assign vrf_re_o[1]    = req_valid_i && !req_i.is_scalar && req_i.use_vs1;
  assign vrf_raddr_o[0] = vreg_addr_t'(req_i.vs2 * VREG_WORDS) + word_q;
  assign vrf_raddr_o[1] = vreg_addr_t'(req_i.vs1 * VREG_WORDS) + word_q;

  assign operands_ok  = &(vrf_rvalid_i | ~vrf_re_o);
  assign lane_valid_o = req_valid_i && operands_ok && (&lane_ready_i);
  assign req_ready_o  = lane_valid_o && last_word;

  //////////////////////////////////////////////////
  // Operands and tag
  //////////////////////////////////////////////////

  always_comb begin
    unique case (req_i.vsew)
      EW_8:    rs1_rep.w = {4{req_i.rs1[7:0]}};
      EW_16:   rs1_rep.w = {2{req_i.rs1[15:0]}};
      default: rs1_rep.w = req_i.rs1;
    endcase
  end

  always_comb begin
    for (int l = 0; l < N_LANES; l++) begin
      lane_in_o[l].op   = req_i.op;
      lane_in_o[l].vsew = req_i.vsew;
      // Scalar work runs on lane 0 alone
      lane_in_o[l].en   = !req_i.is_scalar || (l == 0);
      if (req_i.is_scalar) begin
        lane_in_o[l].op1.w = req_i.rs1;
        lane_in_o[l].op2.w = req_i.rs2;
      end else begin
        lane_in_o[l].op1.w = req_i.use_vs1 ? vrf_rdata_i[1][l*ELEN +: ELEN] : rs1_rep.w;
        lane_in_o[l].op2.w = vrf_rdata_i[0][l*ELEN +: ELEN];
      end
    end
  end

  always_comb begin
    logic [8:0] elem_idx;
    tag_o         = '0;
    tag_o.id      = req_i.id;
    tag_o.vd_addr = vreg_addr_t'(req_i.vd * VREG_WORDS) + word_q;
    tag_o.rd      = req_i.rd;
    tag_o.wb      = req_i.is_scalar;
    tag_o.last    = last_word;
    // Tail mask, byte on when its element sits below vl
    for (int b = 0; b < NB; b++) begin
      elem_idx    = cnt_q + 9'(b >> req_i.vsew);
      tag_o.be[b] = !req_i.is_scalar && (elem_idx < {1'b0, req_i.vl});
    end
  end

  // Follow-on words start inside the vector
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lane_valid_o && !req_i.is_scalar && cnt_q != '0 |-> cnt_q < {1'b0, req_i.vl});

endmodule

`default_nettype wire

//--- source/vfu_lane.sv
// Integer lane of the vector functional unit.
// Two-stage valid/ready pipeline around an element-width ALU.

`timescale 1ns/10ps
`default_nettype none

module vfu_lane (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  vfu_pkg::lane_in_t in_i,
  input  vfu_pkg::vfu_tag_t tag_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  output logic [31:0]       result_o,
  output vfu_pkg::vfu_tag_t tag_o,
  output logic              out_valid_o,
  input  logic              out_ready_i
);
  import vfu_pkg::*;

  lane_in_t   s1_in_q;
  vfu_tag_t   s1_tag_q;
  logic       s1_valid_q;
  lane_word_u s2_res_q;
  vfu_tag_t   s2_tag_q;
  logic       s2_valid_q;
  logic       s2_en_q;
  logic       s1_ready;
  logic       s2_ready;
  lane_word_u alu_res;

  // One element, vs2 op vs1 (rs2 op rs1 for scalar work)
  function automatic logic [31:0] elem_op(input vfu_op_e op, input logic signed [31:0] a,
                                          input logic signed [31:0] b);
    unique case (op)
      VADD:    return b + a;
      VSUB:    return b - a;
      VAND:    return b & a;
      VOR:     return b | a;
      VXOR:    return b ^ a;
      VMIN:    return (b < a) ? b : a;
      VMAX:    return (b > a) ? b : a;
      default: return b;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  // Sign-extended per element, then cut back so carries stay inside
  always_comb begin
    logic [31:0] tmp;
    alu_res.w = '0;
    tmp       = '0;
    unique case (s1_in_q.vsew)
      EW_8: begin
        for (int i = 0; i < 4; i++) begin
          tmp          = elem_op(s1_in_q.op, $signed(s1_in_q.op1.b[i]), $signed(s1_in_q.op2.b[i]));
          alu_res.b[i] = tmp[7:0];
        end
      end
      EW_16: begin
        for (int i = 0; i < 2; i++) begin
          tmp          = elem_op(s1_in_q.op, $signed(s1_in_q.op1.h[i]), $signed(s1_in_q.op2.h[i]));
          alu_res.h[i] = tmp[15:0];
        end
      end
      default: alu_res.w = elem_op(s1_in_q.op, $signed(s1_in_q.op1.w), $signed(s1_in_q.op2.w));
    endcase
  end

  //////////////////////////////////////////////////
  // Pipeline
  //////////////////////////////////////////////////

  assign s2_ready   = !s2_valid_q || out_ready_i;
  assign s1_ready   = !s1_valid_q || s2_ready;
  assign in_ready_o = s1_ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      // Disabled lanes carry a bubble so all lanes stay in step
      if (s1_ready) begin
        s1_valid_q <= in_valid_i;
      end
      if (s2_ready) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_ready && in_valid_i) begin
      s1_in_q  <= in_i;
      s1_tag_q <= tag_i;
    end
    if (s2_ready && s1_valid_q) begin
      s2_res_q <= alu_res;
      s2_tag_q <= s1_tag_q;
      s2_en_q  <= s1_in_q.en;
    end
  end

  assign result_o    = s2_res_q.w;
  assign tag_o       = s2_tag_q;
  assign out_valid_o = s2_valid_q && s2_en_q;

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o));

endmodule

`default_nettype wire

//--- source/vfu_op_queue.sv
// Request queue of the vector functional unit.
// Two-entry spill register, keeps full throughput while issue is stalled.

`timescale 1ns/10ps
`default_nettype none

module vfu_op_queue (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  vfu_pkg::vfu_req_t req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  output vfu_pkg::vfu_req_t req_o,
  output logic              req_valid_o,
  input  logic              req_ready_i
);
  import vfu_pkg::*;

  vfu_req_t a_q;
  vfu_req_t b_q;
  logic     a_full_q;
  logic     b_full_q;
  logic     take_in;
  logic     drain_a;

  assign req_ready_o = !b_full_q;
  assign req_valid_o = a_full_q;
  assign req_o       = a_q;
  assign take_in     = req_valid_i && req_ready_o;
  assign drain_a     = a_full_q && req_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (drain_a) begin
        // Spill slot moves up first, otherwise the new request goes straight to A
        if (b_full_q) begin
          a_q      <= b_q;
          b_full_q <= 1'b0;
        end else if (take_in) begin
          a_q <= req_i;
        end else begin
          a_full_q <= 1'b0;
        end
      end else if (!a_full_q && take_in) begin
        a_q      <= req_i;
        a_full_q <= 1'b1;
      end else if (take_in) begin
        b_q      <= req_i;
        b_full_q <= 1'b1;
      end
    end
  end

  // Head of queue must not change under a stalled issue
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_o));

endmodule

`default_nettype wire

//--- source/vfu_pkg.sv
// Shared definitions of the integer vector functional unit.
// Holds lane geometry, the encodings, the request and response structs and the lane word view.

`default_nettype none

package vfu_pkg;

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////

  localparam int unsigned ELEN       = 32;
  localparam int unsigned ELENB      = ELEN / 8;
  localparam int unsigned VREG_WORDS = 8;

  typedef logic [7:0] vreg_addr_t;
  typedef logic [1:0] vfu_id_t;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vew_e;

  typedef enum logic [2:0] {
    VADD = 3'd0,
    VSUB = 3'd1,
    VAND = 3'd2,
    VOR  = 3'd3,
    VXOR = 3'd4,
    VMIN = 3'd5,
    VMAX = 3'd6
  } vfu_op_e;

  //////////////////////////////////////////////////
  // Interface structs
  //////////////////////////////////////////////////

  typedef struct packed {
    vfu_id_t     id;
    vfu_op_e     op;
    vew_e        vsew;
    logic [7:0]  vl;
    logic [4:0]  vs1;
    logic [4:0]  vs2;
    logic [4:0]  vd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [4:0]  rd;
    logic        use_vs1;
    logic        is_scalar;
  } vfu_req_t;

  typedef struct packed {
    vfu_id_t     id;
    logic [4:0]  rd;
    logic        wb;
    logic [31:0] result;
  } vfu_rsp_t;

  // Travels with every word through the lanes
  typedef struct packed {
    vfu_id_t     id;
    vreg_addr_t  vd_addr;
    logic [4:0]  rd;
    logic        wb;
    logic        last;
    logic [31:0] be;
  } vfu_tag_t;

  // One lane word, split by element width
  typedef union packed {
    logic [3:0][7:0]  b;
    logic [1:0][15:0] h;
    logic [31:0]      w;
  } lane_word_u;

  typedef struct packed {
    vfu_op_e    op;
    vew_e       vsew;
    lane_word_u op1;
    lane_word_u op2;
    logic       en;
  } lane_in_t;

endpackage

`default_nettype wire

//--- source/vfu_top.sv
// Top level of the integer vector functional unit.
// Request queue, issue control, N_LANES integer lanes and the writeback.

`timescale 1ns/10ps
`default_nettype none

module vfu_top #(
  parameter int unsigned N_LANES = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  vfu_pkg::vfu_req_t                     req_i,
  input  logic                                  req_valid_i,
  output logic                                  req_ready_o,
  output vfu_pkg::vfu_rsp_t                     rsp_o,
  output logic                                  rsp_valid_o,
  input  logic                                  rsp_ready_i,
  output vfu_pkg::vreg_addr_t [1:0]             vrf_raddr_o,
  output logic [1:0]                            vrf_re_o,
  input  logic [1:0]                            vrf_rvalid_i,
  input  logic [1:0][N_LANES*vfu_pkg::ELEN-1:0] vrf_rdata_i,
  output vfu_pkg::vreg_addr_t                   vrf_waddr_o,
  output logic [N_LANES*vfu_pkg::ELEN-1:0]      vrf_wdata_o,
  output logic [N_LANES*vfu_pkg::ELENB-1:0]     vrf_wbe_o,
  output logic                                  vrf_we_o,
  input  logic                                  vrf_wvalid_i
);
  import vfu_pkg::*;

  vfu_req_t                q_req;
  logic                    q_valid;
  logic                    q_ready;
  lane_in_t [N_LANES-1:0]  lane_in;
  logic                    lane_valid;
  logic [N_LANES-1:0]      lane_ready;
  vfu_tag_t                issue_tag;
  logic [N_LANES*ELEN-1:0] lane_result;
  vfu_tag_t [N_LANES-1:0]  lane_tag;
  logic [N_LANES-1:0]      lane_out_valid;
  logic                    wb_ready;

  vfu_op_queue u_op_queue (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .req_o      (q_req),
    .req_valid_o(q_valid),
    .req_ready_i(q_ready)
  );

  vfu_issue_ctrl #(
    .N_LANES(N_LANES)
  ) u_issue_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (q_req),
    .req_valid_i (q_valid),
    .req_ready_o (q_ready),
    .vrf_raddr_o (vrf_raddr_o),
    .vrf_re_o    (vrf_re_o),
    .vrf_rvalid_i(vrf_rvalid_i),
    .vrf_rdata_i (vrf_rdata_i),
    .lane_in_o   (lane_in),
    .lane_valid_o(lane_valid),
    .lane_ready_i(lane_ready),
    .tag_o       (issue_tag)
  );

  for (genvar l = 0; l < N_LANES; l++) begin : gen_lanes
    vfu_lane u_lane (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .in_i       (lane_in[l]),
      .tag_i      (issue_tag),
      .in_valid_i (lane_valid),
      .in_ready_o (lane_ready[l]),
      .result_o   (lane_result[l*ELEN +: ELEN]),
      .tag_o      (lane_tag[l]),
      .out_valid_o(lane_out_valid[l]),
      .out_ready_i(wb_ready)
    );
  end

  vfu_writeback #(
    .N_LANES(N_LANES)
  ) u_writeback (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .result_i      (lane_result),
    .tag_i         (lane_tag[0]),
    .result_valid_i(lane_out_valid),
    .result_ready_o(wb_ready),
    .vrf_waddr_o   (vrf_waddr_o),
    .vrf_wdata_o   (vrf_wdata_o),
    .vrf_wbe_o     (vrf_wbe_o),
    .vrf_we_o      (vrf_we_o),
    .vrf_wvalid_i  (vrf_wvalid_i),
    .rsp_o         (rsp_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_ready_i   (rsp_ready_i)
  );

endmodule

`default_nettype wire

//--- source/vfu_writeback.sv
// Writeback of the vector functional unit.
// Sends vector words to the VRF write port and scalar results to the response,
// then holds the response of a finished vector instruction.

`timescale 1ns/10ps
`default_nettype none

module vfu_writeback #(
  parameter int unsigned N_LANES = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [N_LANES*vfu_pkg::ELEN-1:0]  result_i,
  input  vfu_pkg::vfu_tag_t                 tag_i,
  input  logic [N_LANES-1:0]                result_valid_i,
  output logic                              result_ready_o,
  output vfu_pkg::vreg_addr_t               vrf_waddr_o,
  output logic [N_LANES*vfu_pkg::ELEN-1:0]  vrf_wdata_o,
  output logic [N_LANES*vfu_pkg::ELENB-1:0] vrf_wbe_o,
  output logic                              vrf_we_o,
  input  logic                              vrf_wvalid_i,
  output vfu_pkg::vfu_rsp_t                 rsp_o,
  output logic                              rsp_valid_o,
  input  logic                              rsp_ready_i
);
  import vfu_pkg::*;

  logic     have_word;
  logic     word_done;
  logic     pend_q;
  vfu_rsp_t pend_rsp_q;

  // Lane 0 always carries the word, its tag speaks for all lanes
  assign have_word      = result_valid_i[0] && !pend_q;
  assign word_done      = have_word && (tag_i.wb ? rsp_ready_i : vrf_wvalid_i);
  assign result_ready_o = word_done;

  assign vrf_we_o    = have_word && !tag_i.wb;
  assign vrf_waddr_o = tag_i.vd_addr;
  assign vrf_wdata_o = result_i;
  assign vrf_wbe_o   = tag_i.be[N_LANES*ELENB-1:0];

  always_comb begin
    if (pend_q) begin
      rsp_o       = pend_rsp_q;
      rsp_valid_o = 1'b1;
    end else begin
      rsp_o.id     = tag_i.id;
      rsp_o.rd     = tag_i.rd;
      rsp_o.wb     = 1'b1;
      rsp_o.result = result_i[ELEN-1:0];
      rsp_valid_o  = have_word && tag_i.wb;
    end
  end

  // Pending response after the last vector write
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q <= 1'b0;
    end else if (word_done && !tag_i.wb && tag_i.last) begin
      pend_q <= 1'b1;
    end else if (pend_q && rsp_ready_i) begin
      pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_done && !tag_i.wb && tag_i.last) begin
      pend_rsp_q <= '{id: tag_i.id, rd: tag_i.rd, wb: 1'b0, result: '0};
    end
  end

  // Lanes move in lockstep, scalar words only on lane 0
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    result_valid_i[0] |-> (tag_i.wb ? (result_valid_i >> 1) == '0 : &result_valid_i));

endmodule

`default_nettype wire

//--- testbench/tb_vfu.sv
// Testbench of the integer vector functional unit.
// Random instruction mix with stalls on every interface, checked by
// concurrent assertions against a reference model of the element rules.

`timescale 1ns/10ps
`default_nettype none

module tb_vfu;
  import vfu_pkg::*;

  localparam int unsigned N_LANES = 2;
  localparam int          NB      = N_LANES * ELENB;
  localparam int          N_INSTR = 63;
  localparam int          LIMIT   = 40 * N_INSTR;
  localparam int          SEED    = 85533;

  logic                                 clk = 1'b0;
  logic                                 rst_n;
  vfu_req_t                             req;
  logic                                 req_valid;
  logic                                 req_ready;
  vfu_rsp_t                             rsp;
  logic                                 rsp_valid;
  logic                                 rsp_ready;
  vreg_addr_t [1:0]                     vrf_raddr;
  logic [1:0]                           vrf_re;
  logic [1:0]                           vrf_rvalid;
  logic [1:0][N_LANES*ELEN-1:0]         vrf_rdata;
  vreg_addr_t                           vrf_waddr;
  logic [N_LANES*ELEN-1:0]              vrf_wdata;
  logic [NB-1:0]                        vrf_wbe;
  logic                                 vrf_we;
  logic                                 vrf_wvalid;
  int                                   wr_cnt;
  int                                   vrf_err;

  vfu_req_t prog [N_INSTR];
  vfu_rsp_t exp_rsp [N_INSTR];
  int       wr_end [N_INSTR];
  bit       gap [N_INSTR];
  vfu_rsp_t exp_now_rsp;
  int       exp_now_wr_end;
  int       rsp_idx = 0;
  int       cycles  = 0;
  int       err_cnt = 0;
  int       end_err = 0;
  int       total_wr;
  int       seed;

  always #10 clk = ~clk;

  vfu_top #(
    .N_LANES(N_LANES)
  ) u_vfu_top (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .rsp_o       (rsp),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .vrf_raddr_o (vrf_raddr),
    .vrf_re_o    (vrf_re),
    .vrf_rvalid_i(vrf_rvalid),
    .vrf_rdata_i (vrf_rdata),
    .vrf_waddr_o (vrf_waddr),
    .vrf_wdata_o (vrf_wdata),
    .vrf_wbe_o   (vrf_wbe),
    .vrf_we_o    (vrf_we),
    .vrf_wvalid_i(vrf_wvalid)
  );

  tb_vrf_model #(
    .N_LANES(N_LANES),
    .SEED   (SEED)
  ) u_vrf (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .raddr_i  (vrf_raddr),
    .re_i     (vrf_re),
    .rvalid_o (vrf_rvalid),
    .rdata_o  (vrf_rdata),
    .waddr_i  (vrf_waddr),
    .wdata_i  (vrf_wdata),
    .wbe_i    (vrf_wbe),
    .we_i     (vrf_we),
    .wvalid_o (vrf_wvalid),
    .wr_cnt_o (wr_cnt),
    .err_cnt_o(vrf_err)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // One element of the given width, vs2 op vs1
  function automatic logic [31:0] elem_ref(input vfu_op_e op, input int bits,
                                           input logic [31:0] a, input logic [31:0] b);
    logic [31:0] mask;
    logic [31:0] r;
    int          sa;
    int          sb;
    mask = (bits == 32) ? 32'hffff_ffff : ((32'd1 << bits) - 32'd1);
    sa   = $signed(a << (32 - bits)) >>> (32 - bits);
    sb   = $signed(b << (32 - bits)) >>> (32 - bits);
    case (op)
      VADD:    r = b + a;
      VSUB:    r = b - a;
      VAND:    r = b & a;
      VOR:     r = b | a;
      VXOR:    r = b ^ a;
      VMIN:    r = (sb < sa) ? b : a;
      VMAX:    r = (sb > sa) ? b : a;
      default: r = b;
    endcase
    return r & mask;
  endfunction

  function automatic logic [31:0] word_ref(input vfu_op_e op, input vew_e vsew,
                                           input logic [31:0] a, input logic [31:0] b);
    int          bits;
    logic [31:0] res;
    bits = 8 << vsew;
    res  = '0;
    for (int e = 0; e < 32 / bits; e++) begin
      res = res | (elem_ref(op, bits, a >> (e * bits), b >> (e * bits)) << (e * bits));
    end
    return res;
  endfunction

  function automatic logic [31:0] replicate_scalar(input logic [31:0] x, input vew_e vsew);
    int          bits;
    logic [31:0] mask;
    logic [31:0] res;
    bits = 8 << vsew;
    mask = (bits == 32) ? 32'hffff_ffff : ((32'd1 << bits) - 32'd1);
    res  = '0;
    for (int e = 0; e < 32 / bits; e++) begin
      res = res | ((x & mask) << (e * bits));
    end
    return res;
  endfunction

  // Sources live in registers 0 to 15, results in 16 to 31
  task automatic build_program();
    vfu_req_t                r;
    int                      bits;
    int                      epw;
    int                      nwords;
    int                      wr_total;
    logic [N_LANES*ELEN-1:0] src1;
    logic [N_LANES*ELEN-1:0] src2;
    logic [N_LANES*ELEN-1:0] word;
    logic [31:0]             op1;
    logic [31:0]             lane_res;
    wr_total = 0;
    for (int i = 0; i < N_INSTR; i++) begin
      r           = '0;
      r.id        = vfu_id_t'(i);
      r.op        = vfu_op_e'(i % 7);
      r.vsew      = vew_e'((i / 7) % 3);
      r.is_scalar = (i % 5) == 4;
      r.use_vs1   = ($random(seed) & 1) == 1;
      bits        = 8 << r.vsew;
      epw         = NB * 8 / bits;
      r.vl        = 8'(1 + (($random(seed) & 32'h7fff_ffff) % (VREG_WORDS * epw)));
      r.vs1       = 5'($random(seed) & 15);
      r.vs2       = 5'($random(seed) & 15);
      r.vd        = 5'(16 + ($random(seed) & 15));
      r.rs1       = $random(seed);
      r.rs2       = $random(seed);
      r.rd        = 5'($random(seed) & 31);
      gap[i]      = ($random(seed) & 3) == 0;
      if (r.is_scalar) begin
        exp_rsp[i] = '{id: r.id, rd: r.rd, wb: 1'b1,
                       result: word_ref(r.op, r.vsew, r.rs1, r.rs2)};
      end else begin
        exp_rsp[i] = '{id: r.id, rd: r.rd, wb: 1'b0, result: 32'd0};
        nwords     = (r.vl + epw - 1) / epw;
        for (int w = 0; w < nwords; w++) begin
          src2 = u_vrf.golden[r.vs2 * VREG_WORDS + w];
          src1 = u_vrf.golden[r.vs1 * VREG_WORDS + w];
          word = u_vrf.golden[r.vd * VREG_WORDS + w];
          for (int l = 0; l < N_LANES; l++) begin
            op1      = r.use_vs1 ? src1[l*32 +: 32] : replicate_scalar(r.rs1, r.vsew);
            lane_res = word_ref(r.op, r.vsew, op1, src2[l*32 +: 32]);
            for (int b = 0; b < 4; b++) begin
              // Only elements below vl reach the VRF
              if (w * epw + (l * 4 + b) / (bits / 8) < r.vl) begin
                word[(l*4+b)*8 +: 8] = lane_res[b*8 +: 8];
              end
            end
          end
          u_vrf.expect_word(vreg_addr_t'(r.vd * VREG_WORDS + w), word);
          wr_total++;
        end
      end
      wr_end[i] = wr_total;
      prog[i]   = r;
    end
    total_wr = wr_total;
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic send_request(input vfu_req_t r);
    @(negedge clk);
    req       = r;
    req_valid = 1'b1;
    while (!req_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  always @(negedge clk) begin
    rsp_ready <= ($random(seed) & 3) != 0;
  end

  always @(posedge clk) begin
    if (rst_n && rsp_valid && rsp_ready) begin
      rsp_idx <= rsp_idx + 1;
    end
  end

  initial begin
    seed      = SEED;
    rst_n     = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b0;
    #1;
    build_program();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < N_INSTR; i++) begin
      if (gap[i]) begin
        @(negedge clk);
        req_valid = 1'b0;
      end
      send_request(prog[i]);
    end
    @(negedge clk);
    req_valid = 1'b0;
    wait (rsp_idx == N_INSTR);
    repeat (2) @(negedge clk);
    u_vrf.check_memory();
    assert (wr_cnt == total_wr)
      else begin
        end_err++;
        $display("ERR %0t wr_cnt exp %0d got %0d", $time, total_wr, wr_cnt);
      end
    $display("Errors: %0d assertion, %0d VRF model, %0d final", err_cnt, vrf_err, end_err);
    if (err_cnt == 0 && vrf_err == 0 && end_err == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Run stopped after %0d cycles with %0d of %0d responses seen",
               cycles, rsp_idx, N_INSTR);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  assign exp_now_rsp    = (rsp_idx < N_INSTR) ? exp_rsp[rsp_idx] : '0;
  assign exp_now_wr_end = (rsp_idx < N_INSTR) ? wr_end[rsp_idx] : 0;

  assert property (@(posedge clk) !rst_n |=> !vrf_we && vrf_re == 2'b00 && !rsp_valid
                                            && req_ready)
    else begin
      err_cnt++;
      $display("Interfaces not idle right after reset at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> rsp_idx < N_INSTR)
    else begin
      err_cnt++;
      $display("Extra response at %0t after every instruction was answered", $time);
    end

  // Order, id, rd, wb and scalar result in one compare
  assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && rsp_idx < N_INSTR |-> rsp == exp_now_rsp)
    else begin
      err_cnt++;
      $display("ERR %0t rsp_o exp %0h got %0h", $time, $sampled(exp_now_rsp), $sampled(rsp));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && rsp_idx < N_INSTR |-> wr_cnt >= exp_now_wr_end)
    else begin
      err_cnt++;
      $display("Response %0d at %0t came before its last VRF write", $sampled(rsp_idx), $time);
    end

endmodule

`default_nettype wire

//--- testbench/tb_vrf_model.sv
// Behavioral vector register file for the testbench.
// Combinational reads with random read and write stalls, a golden copy
// and a check of every accepted write against the expected word.

`timescale 1ns/10ps
`default_nettype none

module tb_vrf_model #(
  parameter int unsigned N_LANES = 2,
  parameter int          SEED    = 1,
  parameter int          MAX_WR  = 1024
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  vfu_pkg::vreg_addr_t [1:0]             raddr_i,
  input  logic [1:0]                            re_i,
  output logic [1:0]                            rvalid_o,
  output logic [1:0][N_LANES*vfu_pkg::ELEN-1:0] rdata_o,
  input  vfu_pkg::vreg_addr_t                   waddr_i,
  input  logic [N_LANES*vfu_pkg::ELEN-1:0]      wdata_i,
  input  logic [N_LANES*vfu_pkg::ELENB-1:0]     wbe_i,
  input  logic                                  we_i,
  output logic                                  wvalid_o,
  output int                                    wr_cnt_o,
  output int                                    err_cnt_o
);
  import vfu_pkg::*;

  localparam int W = N_LANES * ELEN;

  logic [W-1:0] mem [256];
  logic [W-1:0] golden [256];
  vreg_addr_t   exp_addr [MAX_WR];
  logic [W-1:0] exp_word [MAX_WR];
  int           exp_cnt = 0;
  int           wr_cnt  = 0;
  int           err_cnt = 0;
  int           seed;
  logic [1:0]   rd_ok;
  logic         wr_fire;
  logic [W-1:0] merged;
  vreg_addr_t   exp_now_addr;
  logic [W-1:0] exp_now_word;

  initial begin
    seed     = SEED;
    rd_ok    = 2'b00;
    wvalid_o = 1'b0;
    // Random start contents, every word drawn on its own
    for (int a = 0; a < 256; a++) begin
      for (int l = 0; l < N_LANES; l++) begin
        mem[a][l*32 +: 32] = $random(seed);
      end
      golden[a] = mem[a];
    end
  end

  // Read and write stalls
  always @(negedge clk_i) begin
    rd_ok[0] <= ($random(seed) & 3) != 0;
    rd_ok[1] <= ($random(seed) & 3) != 0;
    wvalid_o <= ($random(seed) & 3) != 0;
  end

  // A port answers only while it is read, with garbage otherwise
  assign rvalid_o   = re_i & rd_ok;
  assign rdata_o[0] = rvalid_o[0] ? mem[raddr_i[0]] : ~mem[raddr_i[0]];
  assign rdata_o[1] = rvalid_o[1] ? mem[raddr_i[1]] : ~mem[raddr_i[1]];

  //////////////////////////////////////////////////
  // Writes
  //////////////////////////////////////////////////

  assign wr_fire      = we_i && wvalid_o;
  assign exp_now_addr = exp_addr[wr_cnt];
  assign exp_now_word = exp_word[wr_cnt];

  always_comb begin
    for (int b = 0; b < W / 8; b++) begin
      merged[b*8 +: 8] = wbe_i[b] ? wdata_i[b*8 +: 8] : mem[waddr_i][b*8 +: 8];
    end
  end

  always @(posedge clk_i) begin
    if (rst_n_i && wr_fire) begin
      mem[waddr_i] <= merged;
      wr_cnt       <= wr_cnt + 1;
    end
  end

  assign wr_cnt_o  = wr_cnt;
  assign err_cnt_o = err_cnt;

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_fire |-> wr_cnt < exp_cnt)
    else begin
      err_cnt++;
      $display("VRF write to address %0d at %0t was not expected", $sampled(waddr_i), $time);
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_fire && wr_cnt < exp_cnt |-> waddr_i == exp_now_addr)
    else begin
      err_cnt++;
      $display("ERR %0t vrf_waddr_o exp %0d got %0d", $time, $sampled(exp_now_addr),
               $sampled(waddr_i));
    end

  // Bytes past the tail keep the old contents
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_fire && wr_cnt < exp_cnt |-> merged == exp_now_word)
    else begin
      err_cnt++;
      $display("ERR %0t vrf_wdata_o exp %0h got %0h", $time, $sampled(exp_now_word),
               $sampled(merged));
    end

  // Called by the testbench for each expected write, in order
  task automatic expect_word(input vreg_addr_t addr, input logic [W-1:0] word);
    golden[addr]      = word;
    exp_addr[exp_cnt] = addr;
    exp_word[exp_cnt] = word;
    exp_cnt++;
  endtask

  task automatic check_memory();
    for (int a = 0; a < 256; a++) begin
      assert (mem[a] == golden[a])
        else begin
          err_cnt++;
          $display("ERR %0t vrf_mem[%0d] exp %0h got %0h", $time, a, golden[a], mem[a]);
        end
    end
  endtask

endmodule

`default_nettype wire
